/* rtl/clk_cfg_sync.sv */
// I2S clock configuration, staged in the bus clock domain
// A req/ack handover copies it into the peripheral clock domain

`timescale 1ns/1ps

module clk_cfg_sync (
    input  logic                      clk_i,
    input  logic                      periph_clk_i,
    input  logic                      rstn_i,
    input  logic                      wr_i,
    input  logic [31:0]               cfg_data_i,
    output logic                      master_lock_o,
    output logic                      slave_lock_o,
    output logic [31:0]               rd_word_o,
    output i2s_cfg_pkg::clk_gen_cfg_t clk_cfg_o
);

    typedef enum logic [1:0] {
        IDLE      = 2'd0,
        WAIT_ACK  = 2'd1,
        WAIT_DROP = 2'd2
    } hs_state_e;

    i2s_regmap_pkg::clkcfg_word_t s_wr_word;
    i2s_regmap_pkg::clkcfg_word_t r_stage;
    i2s_regmap_pkg::clkcfg_word_t s_rd_word;

    hs_state_e r_state;
    hs_state_e s_state_nxt;
    logic      r_dirty;
    logic      s_dirty_nxt;
    logic      s_req;
    logic      [1:0] r_ack_sync;
    logic      [2:0] r_req_sync;     // Two sync stages plus edge history
    logic      s_capture;

    ////////////////////
    // Bus clock domain
    ////////////////////

    always_comb
    begin
        s_wr_word         = cfg_data_i;
        s_wr_word.pending = 1'b0;
        s_wr_word.rsvd    = 1'b0;
    end

    always_ff @(posedge clk_i, negedge rstn_i)
    begin
        if (!rstn_i)
            r_stage <= '0;
        else if (wr_i)
            r_stage <= s_wr_word;
    end

    always_comb
    begin
        s_state_nxt = r_state;
        s_dirty_nxt = r_dirty;
        case (r_state)
            IDLE:
                if (wr_i)
                    s_state_nxt = WAIT_ACK;
            WAIT_ACK:
            begin
                if (wr_i)
                    s_dirty_nxt = 1'b1;  // Sent copy may be stale
                if (r_ack_sync[1])
                    s_state_nxt = WAIT_DROP;
            end
            WAIT_DROP:
            begin
                if (wr_i)
                    s_dirty_nxt = 1'b1;
                if (!r_ack_sync[1])
                begin
                    // Resend so the last write always lands
                    s_state_nxt = s_dirty_nxt ? WAIT_ACK : IDLE;
                    s_dirty_nxt = 1'b0;
                end
            end
            default:
                s_state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk_i, negedge rstn_i)
    begin
        if (!rstn_i)
        begin
            r_state    <= IDLE;
            r_dirty    <= 1'b0;
            r_ack_sync <= 2'b00;
        end
        else
        begin
            r_state    <= s_state_nxt;
            r_dirty    <= s_dirty_nxt;
            r_ack_sync <= {r_ack_sync[0], r_req_sync[2]};
        end
    end

    assign s_req = (r_state == WAIT_ACK);

    always_comb
    begin
        s_rd_word         = r_stage;
        s_rd_word.pending = (r_state != IDLE);
    end

    assign rd_word_o     = s_rd_word;
    assign master_lock_o = r_stage.mst_clk_en;
    assign slave_lock_o  = r_stage.slv_clk_en;

    ////////////////////
    // Peripheral domain
    ////////////////////

    assign s_capture = r_req_sync[1] & ~r_req_sync[2];  // Request rising edge

    always_ff @(posedge periph_clk_i, negedge rstn_i)
    begin
        if (!rstn_i)
        begin
            r_req_sync <= 3'b000;
            clk_cfg_o  <= '0;
        end
        else
        begin
            r_req_sync <= {r_req_sync[1:0], s_req};
            if (s_capture)
            begin
                clk_cfg_o.master_sel_num <= r_stage.mst_sel_num;
                clk_cfg_o.master_sel_ext <= r_stage.mst_sel_ext;
                clk_cfg_o.slave_sel_num  <= r_stage.slv_sel_num;
                clk_cfg_o.slave_sel_ext  <= r_stage.slv_sel_ext;
                clk_cfg_o.master_clk_en  <= r_stage.mst_clk_en;
                clk_cfg_o.slave_clk_en   <= r_stage.slv_clk_en;
                clk_cfg_o.master_clk_div <= {r_stage.common_div, r_stage.mst_div};
                clk_cfg_o.slave_clk_div  <= {r_stage.common_div, r_stage.slv_div};
            end
        end
    end

    // Transfer ending without a resend leaves both domains in step
    a_copy_delivered : assert property (
        @(posedge clk_i) disable iff (!rstn_i)
        (r_state == WAIT_DROP) && (s_state_nxt == IDLE) |->
            clk_cfg_o.master_clk_div == {r_stage.common_div, r_stage.mst_div} &&
            clk_cfg_o.slave_clk_div == {r_stage.common_div, r_stage.slv_div} &&
            clk_cfg_o.master_clk_en == r_stage.mst_clk_en &&
            clk_cfg_o.slave_clk_en == r_stage.slv_clk_en
    ) else $error("clock copy differs from the staging after a transfer");

endmodule

/* rtl/i2s_cfg_decode.sv */
// Address decode for the I2S configuration bus
// Write strobes fan out one bit per register; reads pick one stored word

`timescale 1ns/1ps

module i2s_cfg_decode (
    input  logic                      cfg_valid_i,
    input  logic                      cfg_rwn_i,
    input  i2s_regmap_pkg::reg_addr_e cfg_addr_i,
    output i2s_regmap_pkg::reg_wr_t   wr_o,
    input  logic [2:0][31:0]          rx_word_i,  // saddr, size, cfg
    input  logic [2:0][31:0]          tx_word_i,
    input  logic [31:0]               clk_word_i,
    input  logic [31:0]               slv_word_i,
    input  logic [31:0]               mst_word_i,
    output logic [31:0]               cfg_data_o
);

    logic s_wr;
    logic s_rd;

    assign s_wr = cfg_valid_i & ~cfg_rwn_i;
    assign s_rd = cfg_valid_i & cfg_rwn_i;

    always_comb
    begin
        wr_o = '0;
        if (s_wr)
        begin
            case (cfg_addr_i)
                i2s_regmap_pkg::RX_SADDR:  wr_o.rx_saddr  = 1'b1;
                i2s_regmap_pkg::RX_SIZE:   wr_o.rx_size   = 1'b1;
                i2s_regmap_pkg::RX_CFG:    wr_o.rx_cfg    = 1'b1;
                i2s_regmap_pkg::TX_SADDR:  wr_o.tx_saddr  = 1'b1;
                i2s_regmap_pkg::TX_SIZE:   wr_o.tx_size   = 1'b1;
                i2s_regmap_pkg::TX_CFG:    wr_o.tx_cfg    = 1'b1;
                i2s_regmap_pkg::CLKCFG:    wr_o.clkcfg    = 1'b1;
                i2s_regmap_pkg::SLV_SETUP: wr_o.slv_setup = 1'b1;
                i2s_regmap_pkg::MST_SETUP: wr_o.mst_setup = 1'b1;
                default:                   wr_o = '0;  // Unmapped, dropped
            endcase
        end
    end

    always_comb
    begin
        cfg_data_o = 32'h0;
        if (s_rd)
        begin
            case (cfg_addr_i)
                i2s_regmap_pkg::RX_SADDR:  cfg_data_o = rx_word_i[0];
                i2s_regmap_pkg::RX_SIZE:   cfg_data_o = rx_word_i[1];
                i2s_regmap_pkg::RX_CFG:    cfg_data_o = rx_word_i[2];
                i2s_regmap_pkg::TX_SADDR:  cfg_data_o = tx_word_i[0];
                i2s_regmap_pkg::TX_SIZE:   cfg_data_o = tx_word_i[1];
                i2s_regmap_pkg::TX_CFG:    cfg_data_o = tx_word_i[2];
                i2s_regmap_pkg::CLKCFG:    cfg_data_o = clk_word_i;
                i2s_regmap_pkg::SLV_SETUP: cfg_data_o = slv_word_i;
                i2s_regmap_pkg::MST_SETUP: cfg_data_o = mst_word_i;
                default:                   cfg_data_o = 32'h0;
            endcase
        end
    end

endmodule

/* rtl/i2s_cfg_pkg.sv */
// Core-side records of the I2S configuration block
// What goes out to the DMA channels and the I2S core, and what comes back

`include "i2s_cfg_settings.svh"

package i2s_cfg_pkg;

    typedef struct packed {
        logic [`I2S_CFG_L2_AWIDTH-1:0]  startaddr;
        logic [`I2S_CFG_TRANS_SIZE-1:0] size;
        logic [1:0]                     datasize;
        logic                           continuous;
        logic                           en;  // One-cycle pulse
        logic                           clr; // One-cycle pulse
    } dma_chan_cfg_t;

    typedef struct packed {
        logic [`I2S_CFG_L2_AWIDTH-1:0]  curr_addr;
        logic [`I2S_CFG_TRANS_SIZE-1:0] bytes_left;
        logic                           pending;
        logic                           en;
    } dma_chan_status_t;

    // Peripheral clock domain
    typedef struct packed {
        logic        master_sel_num;
        logic        master_sel_ext;
        logic        slave_sel_num;
        logic        slave_sel_ext;
        logic        master_clk_en;
        logic        slave_clk_en;
        logic [15:0] master_clk_div; // Common divider in the upper byte
        logic [15:0] slave_clk_div;
    } clk_gen_cfg_t;

    typedef struct packed {
        logic       en;
        logic       two_ch;
        logic       lsb_first;
        logic [4:0] bits_word;
        logic [2:0] words;
    } i2s_setup_t;

endpackage

/* rtl/i2s_cfg_settings.svh */
// Build-time sizes and reset values for the I2S configuration block
// Include wherever the address, size or data size widths are needed

`ifndef I2S_CFG_SETTINGS_SVH
`define I2S_CFG_SETTINGS_SVH

// L2 word address width, no alignment bits
`define I2S_CFG_L2_AWIDTH    12

`define I2S_CFG_TRANS_SIZE   16 // Byte count width
`define I2S_CFG_DATASIZE_RST 2  // 32-bit transfers out of reset

`endif

/* rtl/i2s_regmap_pkg.sv */
// Bus-side view of the I2S configuration registers
// Word addresses, per-register write strobes and 32-bit word layouts

package i2s_regmap_pkg;

    // Word addresses, offsets 0x00 to 0x28
    typedef enum logic [4:0] {
        RX_SADDR  = 5'd0,
        RX_SIZE   = 5'd1,
        RX_CFG    = 5'd2,
        TX_SADDR  = 5'd4,
        TX_SIZE   = 5'd5,
        TX_CFG    = 5'd6,
        CLKCFG    = 5'd8,
        SLV_SETUP = 5'd9,
        MST_SETUP = 5'd10
    } reg_addr_e;

    typedef struct packed {
        logic mst_setup;
        logic slv_setup;
        logic clkcfg;
        logic tx_cfg;
        logic tx_size;
        logic tx_saddr;
        logic rx_cfg;
        logic rx_size;
        logic rx_saddr;
    } reg_wr_t;

    typedef struct packed {
        logic [25:0] rsvd;
        logic        clr_pend;   // Clear on write, pending on read
        logic        en;
        logic        rsvd0;
        logic [1:0]  datasize;
        logic        continuous;
    } chan_cfg_word_t;

    typedef struct packed {
        logic       mst_sel_num;
        logic       mst_sel_ext;
        logic       slv_sel_num;
        logic       slv_sel_ext;
        logic       pending;     // Read only
        logic       rsvd;
        logic       mst_clk_en;
        logic       slv_clk_en;
        logic [7:0] common_div;
        logic [7:0] slv_div;
        logic [7:0] mst_div;
    } clkcfg_word_t;

    typedef struct packed {
        logic        en;
        logic [12:0] rsvd2;
        logic        two_ch;
        logic        lsb_first;
        logic [2:0]  rsvd1;
        logic [4:0]  bits_word;
        logic [4:0]  rsvd0;
        logic [2:0]  words;
    } setup_word_t;

endpackage

/* rtl/i2s_setup_reg.sv */
// I2S frame setup register, one per clock generator
// Writes are dropped while the matching clock is enabled

`timescale 1ns/1ps

module i2s_setup_reg #(
    parameter type payload_t = i2s_cfg_pkg::i2s_setup_t
) (
    input  logic        clk_i,
    input  logic        rstn_i,
    input  logic        wr_i,
    input  logic        lock_i,
    input  logic [31:0] cfg_data_i,
    output payload_t    setup_o,
    output logic [31:0] rd_word_o
);

    i2s_regmap_pkg::setup_word_t s_wr_word;
    i2s_regmap_pkg::setup_word_t s_rd_word;

    assign s_wr_word = cfg_data_i;

    always_ff @(posedge clk_i, negedge rstn_i)
    begin
        if (!rstn_i)
            setup_o <= '0;
        else if (wr_i && !lock_i)
        begin
            setup_o.en        <= s_wr_word.en;
            setup_o.two_ch    <= s_wr_word.two_ch;
            setup_o.lsb_first <= s_wr_word.lsb_first;
            setup_o.bits_word <= s_wr_word.bits_word;
            setup_o.words     <= s_wr_word.words;
        end
    end

    always_comb
    begin
        s_rd_word           = '0;  // Reserved bits read zero
        s_rd_word.en        = setup_o.en;
        s_rd_word.two_ch    = setup_o.two_ch;
        s_rd_word.lsb_first = setup_o.lsb_first;
        s_rd_word.bits_word = setup_o.bits_word;
        s_rd_word.words     = setup_o.words;
    end

    assign rd_word_o = s_rd_word;

endmodule

/* rtl/udma_chan_regs.sv */
// Register set of one uDMA channel: start address, size and config
// Config writes also fire the one-cycle enable and clear pulses

`timescale 1ns/1ps

`include "i2s_cfg_settings.svh"

module udma_chan_regs (
    input  logic                          clk_i,
    input  logic                          rstn_i,
    input  logic                          wr_saddr_i,
    input  logic                          wr_size_i,
    input  logic                          wr_cfg_i,
    input  logic [31:0]                   cfg_data_i,
    input  i2s_cfg_pkg::dma_chan_status_t status_i,
    output i2s_cfg_pkg::dma_chan_cfg_t    cfg_o,
    output logic [2:0][31:0]              rd_words_o
);

    i2s_regmap_pkg::chan_cfg_word_t s_wr_word;
    i2s_regmap_pkg::chan_cfg_word_t s_rd_cfg;

    assign s_wr_word = cfg_data_i;

    always_ff @(posedge clk_i, negedge rstn_i)
    begin
        if (!rstn_i)
        begin
            cfg_o.startaddr  <= '0;
            cfg_o.size       <= '0;
            cfg_o.datasize   <= 2'(`I2S_CFG_DATASIZE_RST);
            cfg_o.continuous <= 1'b0;
            cfg_o.en         <= 1'b0;
            cfg_o.clr        <= 1'b0;
        end
        else
        begin
            // Pulses drop again unless a new config write arrives
            cfg_o.en  <= wr_cfg_i & s_wr_word.en;
            cfg_o.clr <= wr_cfg_i & s_wr_word.clr_pend;

            if (wr_saddr_i)
                cfg_o.startaddr <= cfg_data_i[`I2S_CFG_L2_AWIDTH-1:0];
            if (wr_size_i)
                cfg_o.size <= cfg_data_i[`I2S_CFG_TRANS_SIZE-1:0];
            if (wr_cfg_i)
            begin
                cfg_o.datasize   <= s_wr_word.datasize;
                cfg_o.continuous <= s_wr_word.continuous;
            end
        end
    end

    ////////////////////
    // Readback
    ////////////////////

    always_comb
    begin
        s_rd_cfg            = '0;
        s_rd_cfg.clr_pend   = status_i.pending;
        s_rd_cfg.en         = status_i.en;
        s_rd_cfg.datasize   = cfg_o.datasize;
        s_rd_cfg.continuous = cfg_o.continuous;
    end

    // Address and size read the live transfer state
    assign rd_words_o[0] = 32'(status_i.curr_addr);
    assign rd_words_o[1] = 32'(status_i.bytes_left);
    assign rd_words_o[2] = s_rd_cfg;

    a_en_single_pulse : assert property (
        @(posedge clk_i) disable iff (!rstn_i)
        cfg_o.en |=> !cfg_o.en
    ) else $error("channel enable pulse held for two cycles");

endmodule

/* rtl/udma_i2s_cfg.sv */
// Top of the uDMA I2S configuration register block
// Decode, two channel register sets, clock handover and frame setups

`timescale 1ns/1ps

module udma_i2s_cfg (
    input  logic                          clk_i,
    input  logic                          periph_clk_i,
    input  logic                          rstn_i,

    input  logic                          cfg_valid_i,
    input  logic                          cfg_rwn_i,
    input  logic [4:0]                    cfg_addr_i,
    input  logic [31:0]                   cfg_data_i,
    output logic [31:0]                   cfg_data_o,

    input  i2s_cfg_pkg::dma_chan_status_t rx_status_i,
    input  i2s_cfg_pkg::dma_chan_status_t tx_status_i,
    output i2s_cfg_pkg::dma_chan_cfg_t    rx_cfg_o,
    output i2s_cfg_pkg::dma_chan_cfg_t    tx_cfg_o,

    output i2s_cfg_pkg::clk_gen_cfg_t     clk_cfg_o,
    output i2s_cfg_pkg::i2s_setup_t       slave_setup_o,
    output i2s_cfg_pkg::i2s_setup_t       master_setup_o
);

    i2s_regmap_pkg::reg_wr_t s_wr;
    logic [2:0][31:0]        s_rx_words;
    logic [2:0][31:0]        s_tx_words;
    logic [31:0]             s_clk_word;
    logic [31:0]             s_slv_word;
    logic [31:0]             s_mst_word;
    logic                    s_master_lock;
    logic                    s_slave_lock;

    i2s_cfg_decode i2s_cfg_decode_inst (
        .cfg_valid_i (cfg_valid_i),
        .cfg_rwn_i   (cfg_rwn_i),
        .cfg_addr_i  (i2s_regmap_pkg::reg_addr_e'(cfg_addr_i)),
        .wr_o        (s_wr),
        .rx_word_i   (s_rx_words),
        .tx_word_i   (s_tx_words),
        .clk_word_i  (s_clk_word),
        .slv_word_i  (s_slv_word),
        .mst_word_i  (s_mst_word),
        .cfg_data_o  (cfg_data_o)
    );

    udma_chan_regs rx_regs_inst (
        .clk_i      (clk_i),
        .rstn_i     (rstn_i),
        .wr_saddr_i (s_wr.rx_saddr),
        .wr_size_i  (s_wr.rx_size),
        .wr_cfg_i   (s_wr.rx_cfg),
        .cfg_data_i (cfg_data_i),
        .status_i   (rx_status_i),
        .cfg_o      (rx_cfg_o),
        .rd_words_o (s_rx_words)
    );

    udma_chan_regs tx_regs_inst (
        .clk_i      (clk_i),
        .rstn_i     (rstn_i),
        .wr_saddr_i (s_wr.tx_saddr),
        .wr_size_i  (s_wr.tx_size),
        .wr_cfg_i   (s_wr.tx_cfg),
        .cfg_data_i (cfg_data_i),
        .status_i   (tx_status_i),
        .cfg_o      (tx_cfg_o),
        .rd_words_o (s_tx_words)
    );

    clk_cfg_sync clk_cfg_sync_inst (
        .clk_i         (clk_i),
        .periph_clk_i  (periph_clk_i),
        .rstn_i        (rstn_i),
        .wr_i          (s_wr.clkcfg),
        .cfg_data_i    (cfg_data_i),
        .master_lock_o (s_master_lock),
        .slave_lock_o  (s_slave_lock),
        .rd_word_o     (s_clk_word),
        .clk_cfg_o     (clk_cfg_o)
    );

    // Each setup is locked by its own clock enable
    i2s_setup_reg #(
        .payload_t (i2s_cfg_pkg::i2s_setup_t)
    ) slv_setup_inst (
        .clk_i      (clk_i),
        .rstn_i     (rstn_i),
        .wr_i       (s_wr.slv_setup),
        .lock_i     (s_slave_lock),
        .cfg_data_i (cfg_data_i),
        .setup_o    (slave_setup_o),
        .rd_word_o  (s_slv_word)
    );

    i2s_setup_reg #(
        .payload_t (i2s_cfg_pkg::i2s_setup_t)
    ) mst_setup_inst (
        .clk_i      (clk_i),
        .rstn_i     (rstn_i),
        .wr_i       (s_wr.mst_setup),
        .lock_i     (s_master_lock),
        .cfg_data_i (cfg_data_i),
        .setup_o    (master_setup_o),
        .rd_word_o  (s_mst_word)
    );

endmodule

/* tb/udma_i2s_cfg_tb_tasks.svh */
// Bus access, compare and directed test tasks for the configuration testbench
// Included inside the testbench top, after its signal declarations

`ifndef UDMA_I2S_CFG_TB_TASKS_SVH
`define UDMA_I2S_CFG_TB_TASKS_SVH

////////////////////
// Bus access
////////////////////

task automatic strobe_write(input logic [4:0] addr, input logic [31:0] data);
    @(posedge clk_i);
    cfg_valid_i <= 1'b1;
    cfg_rwn_i   <= 1'b0;
    cfg_addr_i  <= addr;
    cfg_data_i  <= data;
endtask

task automatic release_bus();
    @(posedge clk_i);
    cfg_valid_i <= 1'b0;
    cfg_rwn_i   <= 1'b1;
endtask

task automatic bus_write(input logic [4:0] addr, input logic [31:0] data);
    strobe_write(addr, data);
    release_bus();
endtask

task automatic bus_read(input logic [4:0] addr, output logic [31:0] data);
    @(posedge clk_i);
    cfg_valid_i <= 1'b1;
    cfg_rwn_i   <= 1'b1;
    cfg_addr_i  <= addr;
    @(negedge clk_i);
    data = cfg_data_o; // Combinational read data
    release_bus();
endtask

////////////////////
// Compare tasks
////////////////////

task automatic check_word(input string what, input logic [31:0] got, input logic [31:0] exp);
    n_checks++;
    if (got !== exp)
    begin
        n_errors++;
        $display("Error at %0t ns: %s read %h, expected %h", $time, what, got, exp);
    end
endtask

task automatic check_chan(input string what, input i2s_cfg_pkg::dma_chan_cfg_t got,
                          input i2s_cfg_pkg::dma_chan_cfg_t exp);
    n_checks++;
    if (got !== exp)
    begin
        n_errors++;
        $display("Error at %0t ns: %s channel cfg %h, expected %h", $time, what, got, exp);
    end
endtask

task automatic check_clk(input string what, input i2s_cfg_pkg::clk_gen_cfg_t got,
                         input i2s_cfg_pkg::clk_gen_cfg_t exp);
    n_checks++;
    if (got !== exp)
    begin
        n_errors++;
        $display("Error at %0t ns: %s clock cfg %h, expected %h", $time, what, got, exp);
    end
endtask

task automatic check_setup(input string what, input i2s_cfg_pkg::i2s_setup_t got,
                           input i2s_cfg_pkg::i2s_setup_t exp);
    n_checks++;
    if (got !== exp)
    begin
        n_errors++;
        $display("Error at %0t ns: %s setup %h, expected %h", $time, what, got, exp);
    end
endtask

////////////////////
// Expected values
////////////////////

function automatic i2s_cfg_pkg::clk_gen_cfg_t expect_clk(input logic [31:0] w);
    i2s_cfg_pkg::clk_gen_cfg_t c;
    c.master_sel_num = w[31];
    c.master_sel_ext = w[30];
    c.slave_sel_num  = w[29];
    c.slave_sel_ext  = w[28];
    c.master_clk_en  = w[25];
    c.slave_clk_en   = w[24];
    c.master_clk_div = {w[23:16], w[7:0]};  // Common byte on top
    c.slave_clk_div  = {w[23:16], w[15:8]};
    return c;
endfunction

function automatic i2s_cfg_pkg::i2s_setup_t expect_setup(input logic [31:0] w);
    i2s_cfg_pkg::i2s_setup_t s;
    s.en        = w[31];
    s.two_ch    = w[17];
    s.lsb_first = w[16];
    s.bits_word = w[12:8];
    s.words     = w[2:0];
    return s;
endfunction

function automatic logic is_mapped(input int a);
    return !(a == 3 || a == 7 || a > 10);
endfunction

function automatic i2s_cfg_pkg::dma_chan_cfg_t chan_out(input bit is_tx);
    return is_tx ? tx_cfg_o : rx_cfg_o;
endfunction

task automatic wait_pending_low(input int max_cycles);
    logic [31:0] rd;
    int          waited;
    rd     = PEND_BIT;
    waited = 0;
    while (rd[27] && waited < max_cycles)
    begin
        bus_read(i2s_regmap_pkg::CLKCFG, rd);
        waited += 2;
    end
    n_checks++;
    if (rd[27])
    begin
        n_errors++;
        $display("Clock pending bit still set after %0d cycles", max_cycles);
    end
endtask

task automatic write_clk(input logic [31:0] w);
    bus_write(i2s_regmap_pkg::CLKCFG, w);
    wait_pending_low(50);
endtask

task automatic end_test(input string name, input int errs_before);
    n_tests++;
    if (n_errors == errs_before)
        $display("%s: ok", name);
    else
        $display("%s: %0d errors", name, n_errors - errs_before);
endtask

////////////////////
// Directed tests
////////////////////

task automatic test_reset_values();
    int                         errs;
    logic [31:0]                rd;
    i2s_cfg_pkg::dma_chan_cfg_t exp;
    errs         = n_errors;
    exp          = '0;
    exp.datasize = `I2S_CFG_DATASIZE_RST;
    for (int a = 0; a < 11; a++)
    begin
        if (is_mapped(a))
        begin
            bus_read(5'(a), rd);
            check_word($sformatf("reset addr %0d", a), rd,
                       (a == 2 || a == 6) ? 32'(`I2S_CFG_DATASIZE_RST) << 1 : 32'h0);
        end
    end
    @(negedge clk_i);
    check_chan("reset rx", rx_cfg_o, exp);
    check_chan("reset tx", tx_cfg_o, exp);
    check_clk("reset", clk_cfg_o, '0);
    check_setup("reset slave", slave_setup_o, '0);
    check_setup("reset master", master_setup_o, '0);
    end_test("reset values", errs);
endtask

task automatic check_channel(input bit is_tx);
    logic [31:0]                   saddr;
    logic [31:0]                   size;
    logic [31:0]                   cfgw;
    logic [31:0]                   rnd;
    logic [31:0]                   rd;
    logic [4:0]                    a_saddr;
    logic [4:0]                    a_size;
    logic [4:0]                    a_cfg;
    string                         nm;
    i2s_cfg_pkg::dma_chan_status_t st;
    i2s_cfg_pkg::dma_chan_cfg_t    exp;
    nm      = is_tx ? "tx" : "rx";
    a_saddr = is_tx ? i2s_regmap_pkg::TX_SADDR : i2s_regmap_pkg::RX_SADDR;
    a_size  = is_tx ? i2s_regmap_pkg::TX_SIZE : i2s_regmap_pkg::RX_SIZE;
    a_cfg   = is_tx ? i2s_regmap_pkg::TX_CFG : i2s_regmap_pkg::RX_CFG;
    saddr   = $random(seed);
    size    = $random(seed);
    bus_write(a_saddr, saddr);
    bus_write(a_size, size);
    exp           = '0;
    exp.startaddr = saddr[`I2S_CFG_L2_AWIDTH-1:0];
    exp.size      = size[`I2S_CFG_TRANS_SIZE-1:0];
    exp.datasize  = `I2S_CFG_DATASIZE_RST;
    @(negedge clk_i);
    check_chan({nm, " saddr/size"}, chan_out(is_tx), exp);

    rnd = $random(seed);
    st  = rnd[$bits(i2s_cfg_pkg::dma_chan_status_t)-1:0];
    @(posedge clk_i);
    if (is_tx)
        tx_status_i <= st;
    else
        rx_status_i <= st;
    bus_read(a_saddr, rd);
    check_word({nm, " curr addr"}, rd, 32'(st.curr_addr));
    bus_read(a_size, rd);
    check_word({nm, " bytes left"}, rd, 32'(st.bytes_left));

    // Enable and clear set, random data size and continuous
    cfgw = ($random(seed) & 32'h7) | 32'h30;
    strobe_write(a_cfg, cfgw);
    @(negedge clk_i);
    check_chan({nm, " strobe cycle"}, chan_out(is_tx), exp);
    release_bus();
    exp.datasize   = cfgw[2:1];
    exp.continuous = cfgw[0];
    exp.en         = 1'b1;
    exp.clr        = 1'b1;
    @(negedge clk_i);
    check_chan({nm, " pulse cycle"}, chan_out(is_tx), exp);
    exp.en  = 1'b0;
    exp.clr = 1'b0;
    @(negedge clk_i);
    check_chan({nm, " after pulse"}, chan_out(is_tx), exp);
    bus_read(a_cfg, rd);
    check_word({nm, " cfg word"}, rd, {26'h0, st.pending, st.en, 1'b0, cfgw[2:0]});
endtask

task automatic test_channels();
    int errs;
    errs = n_errors;
    check_channel(1'b0);
    check_channel(1'b1);
    end_test("channel registers", errs);
endtask

task automatic test_clk_handover();
    int          errs;
    logic [31:0] w;
    logic [31:0] rd;
    errs = n_errors;
    w    = $random(seed);
    bus_write(i2s_regmap_pkg::CLKCFG, w);
    bus_read(i2s_regmap_pkg::CLKCFG, rd);
    check_word("clkcfg in flight", rd, (w & ~CLK_RO_MASK) | PEND_BIT);
    wait_pending_low(50);
    check_clk("handover", clk_cfg_o, expect_clk(w));
    bus_read(i2s_regmap_pkg::CLKCFG, rd);
    check_word("clkcfg settled", rd, w & ~CLK_RO_MASK);
    end_test("clock handover", errs);
endtask

task automatic test_clk_back_to_back();
    int          errs;
    int          waited;
    logic [31:0] w;
    errs   = n_errors;
    waited = 0;
    w      = $random(seed);
    bus_write(i2s_regmap_pkg::CLKCFG, w);
    // Later writes then arrive after the first capture, still in flight
    while (clk_cfg_o !== expect_clk(w) && waited < 50)
    begin
        @(posedge clk_i);
        waited++;
    end
    for (int i = 0; i < 2; i++)
    begin
        w = $random(seed);
        bus_write(i2s_regmap_pkg::CLKCFG, w);
    end
    wait_pending_low(150);  // Needs a second transfer
    check_clk("last of three", clk_cfg_o, expect_clk(w));
    end_test("back-to-back clock writes", errs);
endtask

task automatic test_setup_lock();
    int          errs;
    logic [31:0] clkw;
    logic [31:0] s1;
    logic [31:0] s2;
    logic [31:0] m1;
    logic [31:0] m2;
    logic [31:0] m3;
    logic [31:0] rd;
    errs = n_errors;
    clkw = $random(seed) & ~32'h0300_0000; // Both clock enables off
    s1   = $random(seed);
    s2   = $random(seed);
    m1   = $random(seed);
    m2   = $random(seed);
    m3   = $random(seed);
    write_clk(clkw);
    bus_write(i2s_regmap_pkg::SLV_SETUP, s1);
    @(negedge clk_i);
    check_setup("slave unlocked", slave_setup_o, expect_setup(s1));
    bus_read(i2s_regmap_pkg::SLV_SETUP, rd);
    check_word("slave setup word", rd, s1 & SETUP_MASK);

    write_clk(clkw | 32'h0100_0000);      // Slave clock on
    bus_write(i2s_regmap_pkg::SLV_SETUP, s2);
    bus_write(i2s_regmap_pkg::MST_SETUP, m1);
    @(negedge clk_i);
    check_setup("slave locked", slave_setup_o, expect_setup(s1));
    check_setup("master unlocked", master_setup_o, expect_setup(m1));

    write_clk(clkw | 32'h0300_0000);      // Both clocks on
    bus_write(i2s_regmap_pkg::MST_SETUP, m2);
    @(negedge clk_i);
    check_setup("master locked", master_setup_o, expect_setup(m1));

    write_clk(clkw | 32'h0100_0000);      // Master clock off again
    bus_write(i2s_regmap_pkg::MST_SETUP, m3);
    @(negedge clk_i);
    check_setup("master reopened", master_setup_o, expect_setup(m3));
    check_setup("slave still locked", slave_setup_o, expect_setup(s1));
    bus_read(i2s_regmap_pkg::MST_SETUP, rd);
    check_word("master setup word", rd, m3 & SETUP_MASK);
    end_test("setup lock", errs);
endtask

task automatic test_unmapped();
    int          errs;
    logic [31:0] clkw;
    logic [31:0] s;
    logic [31:0] m;
    logic [31:0] rc;
    logic [31:0] tc;
    logic [31:0] rd;
    logic [31:0] exp_map [0:10];
    errs = n_errors;
    clkw = $random(seed) & ~32'h0F00_0000;
    s    = $random(seed);
    m    = $random(seed);
    rc   = $random(seed) & 32'h7;       // No enable or clear pulse
    tc   = $random(seed) & 32'h7;
    write_clk(clkw);
    bus_write(i2s_regmap_pkg::SLV_SETUP, s);
    bus_write(i2s_regmap_pkg::MST_SETUP, m);
    bus_write(i2s_regmap_pkg::RX_CFG, rc);
    bus_write(i2s_regmap_pkg::TX_CFG, tc);

    exp_map[0]  = 32'(rx_status_i.curr_addr);
    exp_map[1]  = 32'(rx_status_i.bytes_left);
    exp_map[2]  = {26'h0, rx_status_i.pending, rx_status_i.en, 1'b0, rc[2:0]};
    exp_map[3]  = 32'h0;
    exp_map[4]  = 32'(tx_status_i.curr_addr);
    exp_map[5]  = 32'(tx_status_i.bytes_left);
    exp_map[6]  = {26'h0, tx_status_i.pending, tx_status_i.en, 1'b0, tc[2:0]};
    exp_map[7]  = 32'h0;
    exp_map[8]  = clkw;
    exp_map[9]  = s & SETUP_MASK;
    exp_map[10] = m & SETUP_MASK;

    for (int a = 0; a < 32; a++)
    begin
        if (!is_mapped(a))
        begin
            bus_read(5'(a), rd);
            check_word($sformatf("unmapped addr %0d", a), rd, 32'h0);
        end
    end
    for (int a = 0; a < 32; a++)
    begin
        if (!is_mapped(a))
            bus_write(5'(a), $random(seed));
    end
    for (int a = 0; a < 11; a++)
    begin
        if (is_mapped(a))
        begin
            bus_read(5'(a), rd);
            check_word($sformatf("addr %0d after unmapped writes", a), rd, exp_map[a]);
        end
    end
    check_clk("after unmapped writes", clk_cfg_o, expect_clk(clkw));
    end_test("unmapped addresses", errs);
endtask

`endif

/* tb/udma_i2s_cfg_tb.sv */
// Testbench top for the uDMA I2S configuration register block
// Generates both clocks and reset, runs the directed tests in order and
// reports the result; the tasks come from the included tasks header

`timescale 1ns/1ps

`include "i2s_cfg_settings.svh"

module udma_i2s_cfg_tb;

    localparam int CLK_PERIOD    = 8;
    localparam int PCLK_PERIOD   = 20;
    localparam int RESET_CYCLES  = 4;
    // Rough length of each test in bus cycles, in run order
    localparam int TEST_CYCLES   = 25 + 40 + 40 + 70 + 180 + 175;
    localparam int WATCHDOG_NS   = (RESET_CYCLES + TEST_CYCLES) * CLK_PERIOD * 2;

    localparam logic [31:0] SETUP_MASK  = 32'h8003_1F07; // Defined setup bits
    localparam logic [31:0] CLK_RO_MASK = 32'h0C00_0000; // Pending and reserved
    localparam logic [31:0] PEND_BIT    = 32'h0800_0000;

    logic        clk_i;
    logic        periph_clk_i;
    logic        rstn_i;
    logic        cfg_valid_i;
    logic        cfg_rwn_i;
    logic [4:0]  cfg_addr_i;
    logic [31:0] cfg_data_i;
    logic [31:0] cfg_data_o;

    i2s_cfg_pkg::dma_chan_status_t rx_status_i;
    i2s_cfg_pkg::dma_chan_status_t tx_status_i;
    i2s_cfg_pkg::dma_chan_cfg_t    rx_cfg_o;
    i2s_cfg_pkg::dma_chan_cfg_t    tx_cfg_o;
    i2s_cfg_pkg::clk_gen_cfg_t     clk_cfg_o;
    i2s_cfg_pkg::i2s_setup_t       slave_setup_o;
    i2s_cfg_pkg::i2s_setup_t       master_setup_o;

    integer seed;
    int     n_tests;
    int     n_checks;
    int     n_errors;

    udma_i2s_cfg udma_i2s_cfg_inst (
        .clk_i          (clk_i),
        .periph_clk_i   (periph_clk_i),
        .rstn_i         (rstn_i),
        .cfg_valid_i    (cfg_valid_i),
        .cfg_rwn_i      (cfg_rwn_i),
        .cfg_addr_i     (cfg_addr_i),
        .cfg_data_i     (cfg_data_i),
        .cfg_data_o     (cfg_data_o),
        .rx_status_i    (rx_status_i),
        .tx_status_i    (tx_status_i),
        .rx_cfg_o       (rx_cfg_o),
        .tx_cfg_o       (tx_cfg_o),
        .clk_cfg_o      (clk_cfg_o),
        .slave_setup_o  (slave_setup_o),
        .master_setup_o (master_setup_o)
    );

    `include "udma_i2s_cfg_tb_tasks.svh"

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;
    always #(PCLK_PERIOD / 2) periph_clk_i = ~periph_clk_i;

    ////////////////////
    // Test sequence
    ////////////////////

    initial
    begin
        seed         = 32'hb744_94d7;
        n_tests      = 0;
        n_checks     = 0;
        n_errors     = 0;
        clk_i        = 1'b0;
        periph_clk_i = 1'b0;
        rstn_i       = 1'b0;
        cfg_valid_i  = 1'b0;
        cfg_rwn_i    = 1'b1;
        cfg_addr_i   = '0;
        cfg_data_i   = '0;
        rx_status_i  = '0;
        tx_status_i  = '0;

        repeat (RESET_CYCLES) @(posedge clk_i);
        rstn_i <= 1'b1;

        test_reset_values();
        test_channels();
        test_clk_handover();
        test_clk_back_to_back();
        test_setup_lock();
        test_unmapped();

        $display("%0d tests, %0d checks, %0d errors", n_tests, n_checks, n_errors);
        if (n_errors == 0)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end

    initial
    begin
        #(WATCHDOG_NS);
        $display("Watchdog expired, the test sequence did not finish in time");
        $display("Test failed");
        $finish;
    end

endmodule

/* udma_i2s_cfg.f */
+incdir+rtl
+incdir+tb
rtl/i2s_regmap_pkg.sv
rtl/i2s_cfg_pkg.sv
rtl/i2s_cfg_decode.sv
rtl/udma_chan_regs.sv
rtl/i2s_setup_reg.sv
rtl/clk_cfg_sync.sv
rtl/udma_i2s_cfg.sv
tb/udma_i2s_cfg_tb.sv
